// File: files.f
source/uv_rd_pkg.sv
source/uv_candidate_queue.sv
source/uv_level_energy.sv
source/uv_pixel_sse.sv
source/uv_mode_select.sv
source/uv_rd_top.sv
tb/uv_rd_tb.sv

// File: source/uv_candidate_queue.sv
// Candidate queue with credit return
`timescale 1ns/1ns
`default_nettype none

module uv_candidate_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cand_valid,
    input  wire uv_rd_pkg::uv_cand_t   cand,
    input  wire                        slot_free,
    output logic                       credit,
    output logic                       issue,
    output uv_rd_pkg::uv_levels_t      issue_levels,
    output uv_rd_pkg::uv_pixels_t      issue_src,
    output uv_rd_pkg::uv_pixels_t      issue_rec,
    output uv_rd_pkg::uv_tag_t         issue_tag
);
    import uv_rd_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    uv_cand_t         mem [QUEUE_DEPTH];
    uv_cand_t         head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Head goes out whenever the accumulators can take it
    assign issue = (count != '0) && slot_free;
    assign head  = mem[rd_ptr];

    assign issue_levels = head.levels;
    assign issue_src    = head.src;
    assign issue_rec    = head.rec;
    assign issue_tag    = '{mode: head.mode, last: head.last};

    always_ff @(posedge clk) begin
        if (cand_valid) begin
            mem[wr_ptr] <= cand;
        end
    end

    // --------------------
    // Pointers and credits
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // One credit back per issued entry, a cycle later
            credit <= issue;
            if (cand_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (cand_valid && !issue) begin
                count <= count + 1'b1;
            end else if (issue && !cand_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // Upstream never sends without a credit in hand
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        cand_valid |-> (count < CNT_W'(QUEUE_DEPTH))
    ) else $error("candidate sent while queue full");

endmodule

`default_nettype wire

// File: source/uv_level_energy.sv
// Level energy accumulator
`timescale 1ns/1ns
`default_nettype none

module uv_level_energy (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          issue,
    input  wire uv_rd_pkg::uv_levels_t   levels,
    output logic                         slot_free,
    output uv_rd_pkg::energy_t           energy,
    output logic                         energy_done
);
    import uv_rd_pkg::*;

    localparam int BLOCK_W = COEFS * LEVEL_W;

    uv_levels_t         held_levels;
    logic [BLOCK_W-1:0] cur_block;
    energy_t            lane_sq  [LANES];
    energy_t            lane_acc [LANES];
    energy_t            lane_total;
    beat_t              beat_cnt;
    logic               busy;
    logic               sum_ready;

    function automatic energy_t level_square(input level_t v);
        logic signed [2*LEVEL_W-1:0] p;
        p = v * v;
        return energy_t'(p);
    endfunction

    assign slot_free = !busy;

    // --------------------
    // Beat control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            beat_cnt    <= '0;
            sum_ready   <= 1'b0;
            energy_done <= 1'b0;
        end else begin
            // Lanes are complete the cycle after beat 7
            sum_ready   <= busy && (beat_cnt == beat_t'(BEATS - 1));
            energy_done <= sum_ready;
            if (issue) begin
                busy     <= 1'b1;
                beat_cnt <= beat_t'(1);
            end else if (busy) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == beat_t'(BEATS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            held_levels <= levels;
        end
    end

    // Beat 0 reads the queue head directly, later beats the held copy
    assign cur_block = busy ? held_levels[beat_cnt*BLOCK_W +: BLOCK_W]
                            : levels[0 +: BLOCK_W];

    // --------------------
    // Lanes and reduction
    // --------------------
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_sq[i] = level_square(level_t'(cur_block[(2*i)*LEVEL_W +: LEVEL_W]))
                       + level_square(level_t'(cur_block[(2*i+1)*LEVEL_W +: LEVEL_W]));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (issue) begin
                lane_acc[i] <= lane_sq[i];
            end else if (busy) begin
                lane_acc[i] <= lane_acc[i] + lane_sq[i];
            end
        end
    end

    always_comb begin
        lane_total = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_total = lane_total + lane_acc[i];
        end
    end

    always_ff @(posedge clk) begin
        if (sum_ready) begin
            energy <= lane_total;
        end
    end

    a_issue_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |-> slot_free
    ) else $error("issue while energy lanes busy");

endmodule

`default_nettype wire

// File: source/uv_mode_select.sv
// RD score and best mode selector
`timescale 1ns/1ns
`default_nettype none

module uv_mode_select (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        issue,
    input  wire uv_rd_pkg::uv_tag_t    issue_tag,
    input  wire                        energy_done,
    input  wire uv_rd_pkg::energy_t    energy,
    input  wire uv_rd_pkg::sse_t       sse,
    input  wire uv_rd_pkg::lambda_t    lambda,
    output logic                       result_valid,
    output uv_rd_pkg::uv_result_t      result
);
    import uv_rd_pkg::*;

    typedef enum logic {
        st_idle,
        st_in_group
    } group_state_t;

    group_state_t state;
    uv_tag_t      tag_mem [2];
    uv_tag_t      head_tag;
    logic         tag_wr;
    logic         tag_rd;
    logic [1:0]   tag_cnt;
    score_t       cand_score;
    logic         take;

    // --------------------
    // Tag FIFO
    // --------------------
    always_ff @(posedge clk) begin
        if (issue) begin
            tag_mem[tag_wr] <= issue_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_wr  <= 1'b0;
            tag_rd  <= 1'b0;
            tag_cnt <= '0;
        end else begin
            if (issue) begin
                tag_wr <= ~tag_wr;
            end
            if (energy_done) begin
                tag_rd <= ~tag_rd;
            end
            if (issue && !energy_done) begin
                tag_cnt <= tag_cnt + 2'd1;
            end else if (energy_done && !issue) begin
                tag_cnt <= tag_cnt - 2'd1;
            end
        end
    end

    assign head_tag = tag_mem[tag_rd];

    // --------------------
    // Score and best mode
    // --------------------
    always_comb begin
        cand_score = score_t'(sse) + score_t'(lambda) * score_t'(energy);
        // Strict compare so ties keep the earlier mode
        take = (state == st_idle) || (cand_score < result.best_score);
    end

    // Running best doubles as the result register
    always_ff @(posedge clk) begin
        if (energy_done && take) begin
            result <= '{best_mode: head_tag.mode, best_score: cand_score};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            result_valid <= 1'b0;
        end else begin
            result_valid <= energy_done && head_tag.last;
            if (energy_done) begin
                state <= head_tag.last ? st_idle : st_in_group;
            end
        end
    end

    // At most two candidates between issue and done
    a_tag_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue && !energy_done) |-> (tag_cnt < 2'd2)
    ) else $error("tag FIFO overflow");

endmodule

`default_nettype wire

// File: source/uv_pixel_sse.sv
// Pixel SSE accumulator
`timescale 1ns/1ns
`default_nettype none

module uv_pixel_sse (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          issue,
    input  wire uv_rd_pkg::uv_pixels_t   src,
    input  wire uv_rd_pkg::uv_pixels_t   rec,
    output uv_rd_pkg::sse_t              sse,
    output logic                         sse_done
);
    import uv_rd_pkg::*;

    localparam int BLOCK_W = COEFS * PIXEL_W;

    uv_pixels_t         held_src;
    uv_pixels_t         held_rec;
    logic [BLOCK_W-1:0] cur_src;
    logic [BLOCK_W-1:0] cur_rec;
    sse_t               lane_sq  [LANES];
    sse_t               lane_acc [LANES];
    sse_t               lane_total;
    beat_t              beat_cnt;
    logic               busy;
    logic               sum_ready;

    // Squared difference of one sample pair
    function automatic sse_t diff_square(input pixel_t s, input pixel_t r);
        logic signed [PIXEL_W:0]     d;
        logic signed [2*PIXEL_W+1:0] p;
        d = $signed({1'b0, s}) - $signed({1'b0, r});
        p = d * d;
        return sse_t'(p);
    endfunction

    // --------------------
    // Beat control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            beat_cnt  <= '0;
            sum_ready <= 1'b0;
            sse_done  <= 1'b0;
        end else begin
            sum_ready <= busy && (beat_cnt == beat_t'(BEATS - 1));
            sse_done  <= sum_ready;
            if (issue) begin
                busy     <= 1'b1;
                beat_cnt <= beat_t'(1);
            end else if (busy) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == beat_t'(BEATS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            held_src <= src;
            held_rec <= rec;
        end
    end

    assign cur_src = busy ? held_src[beat_cnt*BLOCK_W +: BLOCK_W] : src[0 +: BLOCK_W];
    assign cur_rec = busy ? held_rec[beat_cnt*BLOCK_W +: BLOCK_W] : rec[0 +: BLOCK_W];

    // --------------------
    // Lanes and reduction
    // --------------------
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_sq[i] = diff_square(cur_src[(2*i)*PIXEL_W +: PIXEL_W],
                                     cur_rec[(2*i)*PIXEL_W +: PIXEL_W])
                       + diff_square(cur_src[(2*i+1)*PIXEL_W +: PIXEL_W],
                                     cur_rec[(2*i+1)*PIXEL_W +: PIXEL_W]);
        end
    end

    // First beat loads, so a following candidate starts clean
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (issue) begin
                lane_acc[i] <= lane_sq[i];
            end else if (busy) begin
                lane_acc[i] <= lane_acc[i] + lane_sq[i];
            end
        end
    end

    always_comb begin
        lane_total = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_total = lane_total + lane_acc[i];
        end
    end

    always_ff @(posedge clk) begin
        if (sum_ready) begin
            sse <= lane_total;
        end
    end

    a_issue_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |-> !busy
    ) else $error("issue while SSE lanes busy");

endmodule

`default_nettype wire

// File: source/uv_rd_pkg.sv
// Chroma RD scoring definitions
`default_nettype none

package uv_rd_pkg;

    // --------------------
    // Geometry
    // --------------------
    localparam int BLOCKS  = 8;
    localparam int BEATS   = 8;
    // Coefficients or samples in one 4x4 block
    localparam int COEFS   = 16;
    // Each lane takes two values of the current block per beat
    localparam int LANES   = COEFS / 2;
    localparam int LEVEL_W = 16;
    localparam int PIXEL_W = 8;

    // --------------------
    // Scalar types
    // --------------------
    typedef logic signed [LEVEL_W-1:0] level_t;
    typedef logic        [PIXEL_W-1:0] pixel_t;
    // DC, TM, V, H
    typedef logic        [1:0]         mode_t;
    typedef logic        [31:0]        energy_t;
    typedef logic        [31:0]        sse_t;
    typedef logic        [15:0]        lambda_t;
    typedef logic        [47:0]        score_t;
    typedef logic [$clog2(BEATS)-1:0]  beat_t;

    // Block k occupies slice k, coefficient j inside it slice j
    typedef logic [BLOCKS*COEFS*LEVEL_W-1:0] uv_levels_t;
    typedef logic [BLOCKS*COEFS*PIXEL_W-1:0] uv_pixels_t;

    // --------------------
    // Bundles
    // --------------------
    typedef struct packed {
        mode_t      mode;
        logic       last;
        uv_levels_t levels;
        uv_pixels_t src;
        uv_pixels_t rec;
    } uv_cand_t;

    typedef struct packed {
        mode_t mode;
        logic  last;
    } uv_tag_t;

    typedef struct packed {
        mode_t  best_mode;
        score_t best_score;
    } uv_result_t;

endpackage

`default_nettype wire

// File: source/uv_rd_top.sv
// Chroma RD scoring top
`timescale 1ns/1ns
`default_nettype none

module uv_rd_top #(
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cand_valid,
    input  wire uv_rd_pkg::uv_cand_t   cand,
    input  wire uv_rd_pkg::lambda_t    lambda,
    output logic                       credit,
    output logic                       result_valid,
    output uv_rd_pkg::uv_result_t      result
);
    import uv_rd_pkg::*;

    logic       issue;
    logic       slot_free;
    logic       energy_done;
    logic       sse_done;
    uv_levels_t issue_levels;
    uv_pixels_t issue_src;
    uv_pixels_t issue_rec;
    uv_tag_t    issue_tag;
    energy_t    energy;
    sse_t       sse;

    uv_candidate_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid   (cand_valid),
        .cand         (cand),
        .slot_free    (slot_free),
        .credit       (credit),
        .issue        (issue),
        .issue_levels (issue_levels),
        .issue_src    (issue_src),
        .issue_rec    (issue_rec),
        .issue_tag    (issue_tag)
    );

    // Energy side owns slot_free for both accumulators
    uv_level_energy u_energy (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .levels      (issue_levels),
        .slot_free   (slot_free),
        .energy      (energy),
        .energy_done (energy_done)
    );

    uv_pixel_sse u_sse (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .src      (issue_src),
        .rec      (issue_rec),
        .sse      (sse),
        .sse_done (sse_done)
    );

    uv_mode_select u_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .issue_tag    (issue_tag),
        .energy_done  (energy_done),
        .energy       (energy),
        .sse          (sse),
        .lambda       (lambda),
        .result_valid (result_valid),
        .result       (result)
    );

    // Selector relies on both sums landing together
    a_done_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        sse_done == energy_done
    ) else $error("sse_done and energy_done out of step");

endmodule

`default_nettype wire

// File: tb/uv_rd_tb.sv
// Chroma RD scoring testbench
`timescale 1ns/1ns
`default_nettype none

module uv_rd_tb;
    import uv_rd_pkg::*;

    localparam int QUEUE_DEPTH    = 2;
    localparam int NCOEF          = BLOCKS * COEFS;
    localparam int DRIVE_DLY      = 1;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 300;

    logic       clk;
    logic       rst_n;
    logic       cand_valid;
    uv_cand_t   cand;
    lambda_t    lambda;
    logic       credit;
    logic       result_valid;
    uv_result_t result;

    integer     seed = 32'h544bc210;
    int         credits;
    int         cands_sent;
    int         credits_returned;
    int         max_outstanding;
    int         checks;
    int         errors;
    uv_cand_t   cand_buf [4];
    uv_result_t exp_q [$];
    uv_result_t got_q [$];
    uv_result_t last_result;

    uv_rd_top #(
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_valid   (cand_valid),
        .cand         (cand),
        .lambda       (lambda),
        .credit       (credit),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Output monitor
    // --------------------
    // Sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit) begin
                credits++;
                credits_returned++;
            end
            if (result_valid) begin
                got_q.push_back(result);
            end
            if (cands_sent - credits_returned > max_outstanding) begin
                max_outstanding = cands_sent - credits_returned;
            end
            // Every credit pulse must match a candidate already sent
            if (credits_returned > cands_sent) begin
                errors++;
                $display("FAILED at %0t ns: %0d credits returned for %0d candidates sent",
                         $time, credits_returned, cands_sent);
            end
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic score_t cand_score(input uv_cand_t c, input lambda_t lam);
        energy_t e;
        sse_t    s;
        level_t  lv;
        int      v;
        int      d;
        e = '0;
        s = '0;
        for (int k = 0; k < NCOEF; k++) begin
            lv = c.levels[k*LEVEL_W +: LEVEL_W];
            v  = lv;
            e  = e + energy_t'(v * v);
        end
        for (int k = 0; k < NCOEF; k++) begin
            d = int'(c.src[k*PIXEL_W +: PIXEL_W]) - int'(c.rec[k*PIXEL_W +: PIXEL_W]);
            s = s + sse_t'(d * d);
        end
        return score_t'(s) + score_t'(lam) * score_t'(e);
    endfunction

    // Levels cycle through -2..2 times base, rec is src shifted by diff
    task automatic make_pattern_cand(input mode_t m, input int lvl_base, input int pix_diff,
                                     output uv_cand_t c);
        int px;
        c      = '0;
        c.mode = m;
        for (int k = 0; k < NCOEF; k++) begin
            px = 64 + (k % 64);
            c.levels[k*LEVEL_W +: LEVEL_W] = level_t'(((k % 5) - 2) * lvl_base);
            c.src[k*PIXEL_W +: PIXEL_W]    = pixel_t'(px);
            c.rec[k*PIXEL_W +: PIXEL_W]    = pixel_t'(px + pix_diff);
        end
    endtask

    task automatic make_random_cand(output uv_cand_t c);
        c      = '0;
        c.mode = mode_t'($random(seed));
        for (int k = 0; k < NCOEF; k++) begin
            c.levels[k*LEVEL_W +: LEVEL_W] = level_t'($random(seed) % 64);
            c.src[k*PIXEL_W +: PIXEL_W]    = pixel_t'($random(seed));
            c.rec[k*PIXEL_W +: PIXEL_W]    = pixel_t'($random(seed));
        end
    endtask

    // --------------------
    // Drivers and checkers
    // --------------------
    task automatic send_cand(input uv_cand_t c);
        int waited;
        waited = 0;
        while (credits == 0) begin
            cand_valid = 1'b0;
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
                stop_on_timeout("a credit");
            end
        end
        cand_valid = 1'b1;
        cand       = c;
        credits--;
        cands_sent++;
        @(posedge clk);
        #DRIVE_DLY;
        cand_valid = 1'b0;
    endtask

    // Expected best of cand_buf[0..n-1], then all n sent back to back
    task automatic send_group(input int n);
        uv_result_t best;
        score_t     s;
        for (int i = 0; i < n; i++) begin
            cand_buf[i].last = (i == n - 1);
            s = cand_score(cand_buf[i], lambda);
            if (i == 0 || s < best.best_score) begin
                best.best_mode  = cand_buf[i].mode;
                best.best_score = s;
            end
        end
        exp_q.push_back(best);
        for (int i = 0; i < n; i++) begin
            send_cand(cand_buf[i]);
        end
    endtask

    task automatic check_results();
        uv_result_t exp_r;
        uv_result_t got_r;
        int         waited;
        while (exp_q.size() > 0) begin
            exp_r  = exp_q.pop_front();
            waited = 0;
            while (got_q.size() == 0) begin
                @(posedge clk);
                #DRIVE_DLY;
                waited++;
                if (waited > RESULT_TIMEOUT) begin
                    stop_on_timeout("result_valid");
                end
            end
            got_r       = got_q.pop_front();
            last_result = got_r;
            checks++;
            if (got_r !== exp_r) begin
                errors++;
                $display("FAILED at %0t ns: expected mode %0d score %0d, got mode %0d score %0d",
                         $time, exp_r.best_mode, exp_r.best_score,
                         got_r.best_mode, got_r.best_score);
            end
        end
    endtask

    task automatic wait_credits_home();
        int waited;
        waited = 0;
        while (credits != QUEUE_DEPTH) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
                stop_on_timeout("all credits to return");
            end
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic single_candidate();
        lambda = 16'd3;
        make_pattern_cand(mode_t'(2), 5, 4, cand_buf[0]);
        send_group(1);
        check_results();
    endtask

    // Lowest score sits at the third position
    task automatic four_mode_group();
        lambda = 16'd2;
        make_pattern_cand(mode_t'(0), 2, 7, cand_buf[0]);
        make_pattern_cand(mode_t'(1), 4, 3, cand_buf[1]);
        make_pattern_cand(mode_t'(2), 1, 5, cand_buf[2]);
        make_pattern_cand(mode_t'(3), 3, 2, cand_buf[3]);
        send_group(4);
        check_results();
    endtask

    task automatic tie_keeps_earlier();
        lambda = 16'd7;
        make_pattern_cand(mode_t'(1), 3, 4, cand_buf[0]);
        make_pattern_cand(mode_t'(2), 3, 4, cand_buf[1]);
        send_group(2);
        check_results();
        checks++;
        if (last_result.best_mode !== mode_t'(1)) begin
            errors++;
            $display("FAILED at %0t ns: tie reported mode %0d instead of 1",
                     $time, last_result.best_mode);
        end
    endtask

    // High energy low distortion against zero energy high distortion
    task automatic lambda_sweep();
        mode_t pick_low;
        lambda = 16'd0;
        make_pattern_cand(mode_t'(0), 8, 1, cand_buf[0]);
        make_pattern_cand(mode_t'(3), 0, 6, cand_buf[1]);
        send_group(2);
        check_results();
        pick_low = last_result.best_mode;
        lambda   = 16'd1000;
        make_pattern_cand(mode_t'(0), 8, 1, cand_buf[0]);
        make_pattern_cand(mode_t'(3), 0, 6, cand_buf[1]);
        send_group(2);
        check_results();
        checks++;
        if (pick_low === last_result.best_mode) begin
            errors++;
            $display("FAILED at %0t ns: mode %0d selected for both lambda values",
                     $time, pick_low);
        end
    endtask

    task automatic credit_accounting();
        lambda = 16'd5;
        wait_credits_home();
        for (int g = 0; g < 3; g++) begin
            make_random_cand(cand_buf[0]);
            make_random_cand(cand_buf[1]);
            send_group(2);
        end
        check_results();
        wait_credits_home();
        checks++;
        if (credits_returned != cands_sent || max_outstanding != QUEUE_DEPTH) begin
            errors++;
            $display("FAILED at %0t ns: %0d sent, %0d credits back, peak outstanding %0d",
                     $time, cands_sent, credits_returned, max_outstanding);
        end
    endtask

    task automatic random_groups();
        int n;
        lambda = lambda_t'($random(seed) % 32);
        for (int g = 0; g < 20; g++) begin
            n = 1 + ($unsigned($random(seed)) % 4);
            for (int i = 0; i < n; i++) begin
                make_random_cand(cand_buf[i]);
            end
            send_group(n);
        end
        check_results();
    endtask

    initial begin
        rst_n            = 1'b0;
        cand_valid       = 1'b0;
        cand             = '0;
        lambda           = '0;
        credits          = QUEUE_DEPTH;
        cands_sent       = 0;
        credits_returned = 0;
        max_outstanding  = 0;
        checks           = 0;
        errors           = 0;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        checks++;
        if (credit !== 1'b0 || result_valid !== 1'b0) begin
            errors++;
            $display("FAILED at %0t ns: credit or result_valid high in reset", $time);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        single_candidate();
        four_mode_group();
        tie_keeps_earlier();
        lambda_sweep();
        credit_accounting();
        random_groups();

        // No stray results after the last group
        repeat (20) @(posedge clk);
        checks++;
        if (got_q.size() != 0) begin
            errors++;
            $display("FAILED at %0t ns: %0d unexpected results", $time, got_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
